// File: verilog/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

	// Datapath and register file geometry
	localparam int xlen = 32;
	localparam int regAddrW = 5;
	localparam int shamtW = 5;
	localparam int csrAddrW = 12;

	// Machine-mode CSR addresses
	localparam logic [csrAddrW-1:0] csrMstatus = 12'h300;
	localparam logic [csrAddrW-1:0] csrMtvec = 12'h305;
	localparam logic [csrAddrW-1:0] csrMscratch = 12'h340;
	localparam logic [csrAddrW-1:0] csrMepc = 12'h341;
	localparam logic [csrAddrW-1:0] csrMcause = 12'h342;

	//////////////////////////////////////////////////////////////
	// Memory operation codes, bit 3 marks a load
	localparam int memOpW = 4;
	localparam int memLoadBit = 3;
	localparam logic [memOpW-1:0] memNone = 4'b0000;
	localparam logic [memOpW-1:0] memSb = 4'b0001;
	localparam logic [memOpW-1:0] memSh = 4'b0010;
	localparam logic [memOpW-1:0] memSw = 4'b0011;
	localparam logic [memOpW-1:0] memLb = 4'b1000;
	localparam logic [memOpW-1:0] memLh = 4'b1001;
	localparam logic [memOpW-1:0] memLw = 4'b1010;
	localparam logic [memOpW-1:0] memLbu = 4'b1100;
	localparam logic [memOpW-1:0] memLhu = 4'b1101;

	// Multiply and divide
	localparam int mulDivOpW = 4;
	localparam logic [mulDivOpW-1:0] mulDivNone = 4'b0000;

	// Exception causes
	localparam logic [xlen-1:0] causeIllegal = 32'd2;
	localparam logic [xlen-1:0] causeEcall = 32'd11;

	//////////////////////////////////////////////////////////////
	// mstatus, seen as a raw word or by its enable fields
	typedef struct packed {
		logic [23:0] rsvd31to8;
		logic mpie;
		logic [2:0] rsvd6to4;
		logic mie;
		logic [2:0] rsvd2to0;
	} mstatusFields;

	typedef union packed {
		logic [xlen-1:0] raw;
		mstatusFields f;
	} mstatusWord;

endpackage

`default_nettype wire

// File: verilog/issueCtrlPkg.sv
`default_nettype none

package issueCtrlPkg;

	// Decode fields carried through the issue register
	localparam int aluFnW = 4;
	localparam int bSelW = 2;

	//////////////////////////////////////////////////////////////
	// Operand B sources
	localparam logic [bSelW-1:0] bSelReg = 2'b00;
	localparam logic [bSelW-1:0] bSelImm = 2'b01;
	localparam logic [bSelW-1:0] bSelShamt = 2'b10;

	//////////////////////////////////////////////////////////////
	// Wrong-path bubbles after a taken branch or jump
	localparam int squashDepth = 2;
	localparam int squashCntW = 2;

endpackage

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input  logic clk,
	input  logic nrst,
	input  logic we,
	input  logic [rvIsaPkg::regAddrW-1:0] wAddr,
	input  logic [rvIsaPkg::xlen-1:0] wData,
	input  logic [rvIsaPkg::regAddrW-1:0] rAddrA,
	input  logic [rvIsaPkg::regAddrW-1:0] rAddrB,
	output logic [rvIsaPkg::xlen-1:0] rDataA,
	output logic [rvIsaPkg::xlen-1:0] rDataB
);
	import rvIsaPkg::*;

	// x0 has no storage
	logic [xlen-1:0] regs [1:31];

	// Read with bypass of a writeback in the same cycle
	function automatic logic [xlen-1:0] readPort(input logic [regAddrW-1:0] addr);
		logic [xlen-1:0] value;
		if (addr == '0)
			value = '0;
		else if (we && (wAddr == addr))
			value = wData;
		else
			value = regs[addr];
		return value;
	endfunction

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && (wAddr != '0))
			regs[wAddr] <= wData;
	end

	assign rDataA = readPort(rAddrA);
	assign rDataB = readPort(rAddrB);

endmodule

`default_nettype wire

// File: verilog/hazardScoreboard.sv
`timescale 1ns/100ps
`default_nettype none

module hazardScoreboard (
	input  logic clk,
	input  logic nrst,
	input  logic [rvIsaPkg::regAddrW-1:0] rs1,
	input  logic [rvIsaPkg::regAddrW-1:0] rs2,
	input  logic [rvIsaPkg::regAddrW-1:0] rd3,
	input  logic [rvIsaPkg::mulDivOpW-1:0] mulDivOp3,
	input  logic [rvIsaPkg::regAddrW-1:0] rd4,
	input  logic [rvIsaPkg::memOpW-1:0] memOp4,
	input  logic we6,
	input  logic [rvIsaPkg::regAddrW-1:0] rdAddr6,
	input  logic bjTaken,
	input  logic exception,
	input  logic stallMem,
	output logic stall,
	output logic bubble,
	output logic hold
);
	import rvIsaPkg::*;
	import issueCtrlPkg::*;

	logic [31:0] busy;
	logic [squashCntW-1:0] squashCnt;
	logic squashing;
	logic busyA, busyB;
	logic loadUse;
	logic hazard;
	logic advance;

	//////////////////////////////////////////////////////////////
	// Hazard detection

	// A writeback arriving this cycle releases the register
	assign busyA = busy[rs1] && !(we6 && (rdAddr6 == rs1));
	assign busyB = busy[rs2] && !(we6 && (rdAddr6 == rs2));

	assign loadUse = memOp4[memLoadBit] && (rd4 != '0) && ((rd4 == rs1) || (rd4 == rs2));
	assign hazard = busyA || busyB || loadUse;
	assign squashing = bjTaken || (squashCnt != '0);

	// Exception, squash, hazard, then memory back-pressure
	assign bubble = exception || squashing || hazard;
	assign hold = !bubble && stallMem;
	assign stall = !exception && !squashing && (hazard || stallMem);
	assign advance = !bubble && !hold;

	//////////////////////////////////////////////////////////////
	// Busy bits for multiply and divide destinations

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			busy <= '0;
		else
		begin
			if (we6)
				busy[rdAddr6] <= 1'b0;
			// A new producer wins over a stale writeback
			if (advance && (mulDivOp3 != mulDivNone) && (rd3 != '0))
				busy[rd3] <= 1'b1;
		end
	end

	// The bjTaken cycle is itself the first squash bubble
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			squashCnt <= '0;
		else if (bjTaken)
			squashCnt <= squashCntW'(squashDepth - 1);
		else if (squashCnt != '0)
			squashCnt <= squashCnt - 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog/csrFile.sv
`timescale 1ns/100ps
`default_nettype none

module csrFile (
	input  logic clk,
	input  logic nrst,
	input  logic [rvIsaPkg::csrAddrW-1:0] rAddr,
	input  logic csrWe,
	input  logic [rvIsaPkg::csrAddrW-1:0] wbAddr,
	input  logic [rvIsaPkg::xlen-1:0] wbData,
	input  logic excPending,
	input  logic [rvIsaPkg::xlen-1:0] cause,
	input  logic [rvIsaPkg::xlen-1:0] pcExc,
	input  logic mRet,
	output logic [rvIsaPkg::xlen-1:0] rData,
	output logic [rvIsaPkg::xlen-1:0] epc,
	output logic [rvIsaPkg::xlen-1:0] trapVector
);
	import rvIsaPkg::*;

	mstatusWord mstatus;
	logic [xlen-1:0] mtvec;
	logic [xlen-1:0] mepc;
	logic [xlen-1:0] mcause;
	logic [xlen-1:0] mscratch;

	//////////////////////////////////////////////////////////////
	// Register updates

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			mstatus.raw <= '0;
			mtvec <= '0;
			mepc <= '0;
			mcause <= '0;
			mscratch <= '0;
		end
		else if (excPending)
		begin
			// Trap entry, interrupts off
			mepc <= pcExc;
			mcause <= cause;
			mstatus.f.mpie <= mstatus.f.mie;
			mstatus.f.mie <= 1'b0;
		end
		else if (mRet)
		begin
			mstatus.f.mie <= mstatus.f.mpie;
			mstatus.f.mpie <= 1'b1;
		end
		else if (csrWe)
		begin
			case (wbAddr)
				csrMstatus: mstatus.raw <= wbData;
				csrMtvec: mtvec <= wbData;
				csrMepc: mepc <= wbData;
				csrMcause: mcause <= wbData;
				csrMscratch: mscratch <= wbData;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////
	// Read port, unknown addresses give zero

	always_comb
	begin
		case (rAddr)
			csrMstatus: rData = mstatus.raw;
			csrMtvec: rData = mtvec;
			csrMepc: rData = mepc;
			csrMcause: rData = mcause;
			csrMscratch: rData = mscratch;
			default: rData = '0;
		endcase
	end

	// Frontend redirect targets
	assign epc = mepc;
	assign trapVector = mtvec;

endmodule

`default_nettype wire

// File: verilog/issueStage.sv
`timescale 1ns/100ps
`default_nettype none

module issueStage (
	input  logic clk,
	input  logic nrst,
	// Decode, stage 3
	input  logic [rvIsaPkg::regAddrW-1:0] rs1,
	input  logic [rvIsaPkg::regAddrW-1:0] rs2,
	input  logic [rvIsaPkg::regAddrW-1:0] rd3,
	input  logic we3,
	input  logic [issueCtrlPkg::aluFnW-1:0] aluFn3,
	input  logic [issueCtrlPkg::bSelW-1:0] bSel3,
	input  logic [rvIsaPkg::xlen-1:0] iImm3,
	input  logic [rvIsaPkg::shamtW-1:0] shamt3,
	input  logic [rvIsaPkg::memOpW-1:0] memOp3,
	input  logic [rvIsaPkg::mulDivOpW-1:0] mulDivOp3,
	input  logic [rvIsaPkg::xlen-1:0] pc3,
	input  logic [rvIsaPkg::csrAddrW-1:0] csrAddr3,
	input  logic csrWe3,
	input  logic ecall3,
	input  logic illegal3,
	input  logic mret3,
	// Execute, stage 4
	output logic [rvIsaPkg::xlen-1:0] opA,
	output logic [rvIsaPkg::xlen-1:0] opB,
	output logic [rvIsaPkg::regAddrW-1:0] rd4,
	output logic we4,
	output logic [issueCtrlPkg::aluFnW-1:0] aluFn4,
	output logic [rvIsaPkg::memOpW-1:0] memOp4,
	output logic [rvIsaPkg::mulDivOpW-1:0] mulDivOp4,
	output logic [rvIsaPkg::xlen-1:0] pc4,
	output logic [rvIsaPkg::csrAddrW-1:0] csrAddr4,
	output logic csrWe4,
	output logic [rvIsaPkg::xlen-1:0] csrData,
	output logic ecall4,
	output logic illegal4,
	output logic mret4,
	// Commit writeback
	input  logic we6,
	input  logic [rvIsaPkg::regAddrW-1:0] rdAddr6,
	input  logic [rvIsaPkg::xlen-1:0] wb6,
	input  logic csrWe6,
	input  logic [rvIsaPkg::csrAddrW-1:0] csrWbAddr,
	input  logic [rvIsaPkg::xlen-1:0] csrWb,
	input  logic excPending,
	input  logic [rvIsaPkg::xlen-1:0] cause,
	input  logic [rvIsaPkg::xlen-1:0] pcExc,
	input  logic mRet,
	// Frontend
	output logic [rvIsaPkg::xlen-1:0] epc,
	output logic [rvIsaPkg::xlen-1:0] trapVector,
	// Pipeline control
	input  logic bjTaken,
	input  logic exception,
	input  logic stallMem,
	output logic stall
);
	import rvIsaPkg::*;
	import issueCtrlPkg::*;

	logic [xlen-1:0] rDataA, rDataB;
	logic bubble, hold;

	// Operand B sources held in stage 4
	logic [bSelW-1:0] bSel4;
	logic [xlen-1:0] rs2Val4;
	logic [xlen-1:0] iImm4;
	logic [shamtW-1:0] shamt4;

	regFile regs (
		.clk(clk),
		.nrst(nrst),
		.we(we6),
		.wAddr(rdAddr6),
		.wData(wb6),
		.rAddrA(rs1),
		.rAddrB(rs2),
		.rDataA(rDataA),
		.rDataB(rDataB)
	);

	hazardScoreboard scoreboard (
		.clk(clk),
		.nrst(nrst),
		.rs1(rs1),
		.rs2(rs2),
		.rd3(rd3),
		.mulDivOp3(mulDivOp3),
		.rd4(rd4),
		.memOp4(memOp4),
		.we6(we6),
		.rdAddr6(rdAddr6),
		.bjTaken(bjTaken),
		.exception(exception),
		.stallMem(stallMem),
		.stall(stall),
		.bubble(bubble),
		.hold(hold)
	);

	csrFile csrs (
		.clk(clk),
		.nrst(nrst),
		.rAddr(csrAddr4),
		.csrWe(csrWe6),
		.wbAddr(csrWbAddr),
		.wbData(csrWb),
		.excPending(excPending),
		.cause(cause),
		.pcExc(pcExc),
		.mRet(mRet),
		.rData(csrData),
		.epc(epc),
		.trapVector(trapVector)
	);

	//////////////////////////////////////////////////////////////
	// Stage-4 register, control part

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst || bubble)
		begin
			rd4 <= '0;
			we4 <= 1'b0;
			memOp4 <= memNone;
			mulDivOp4 <= mulDivNone;
			csrWe4 <= 1'b0;
			ecall4 <= 1'b0;
			illegal4 <= 1'b0;
			mret4 <= 1'b0;
		end
		else if (!hold)
		begin
			rd4 <= rd3;
			we4 <= we3;
			memOp4 <= memOp3;
			mulDivOp4 <= mulDivOp3;
			csrWe4 <= csrWe3;
			ecall4 <= ecall3;
			illegal4 <= illegal3;
			mret4 <= mret3;
		end
	end

	// Payload part, a bubble leaves it don't-care
	always_ff @(posedge clk)
	begin
		if (!hold)
		begin
			opA <= rDataA;
			rs2Val4 <= rDataB;
			iImm4 <= iImm3;
			shamt4 <= shamt3;
			bSel4 <= bSel3;
			aluFn4 <= aluFn3;
			pc4 <= pc3;
			csrAddr4 <= csrAddr3;
		end
	end

	//////////////////////////////////////////////////////////////
	// Operand B select

	always_comb
	begin
		case (bSel4)
			bSelReg: opB = rs2Val4;
			bSelImm: opB = iImm4;
			bSelShamt: opB = {{(xlen - shamtW){1'b0}}, shamt4};
			default: opB = rs2Val4;
		endcase
	end

endmodule

`default_nettype wire

// File: sim/issueStage_properties.sv
`timescale 1ns/100ps
`default_nettype none

module issueStageProperties (
	input  logic clk,
	input  logic nrst,
	input  logic bjTaken,
	input  logic we4,
	input  logic stall,
	input  logic hold,
	input  logic [rvIsaPkg::regAddrW-1:0] rd4
);

	// Two wrong-path slots after a taken branch or jump
	squashWindow: assert property (@(posedge clk) disable iff (!nrst)
		bjTaken |=> !we4 [*2])
		else $error("we4 high inside the squash window after bjTaken");

	// Pipeline starts out free
	stallAfterReset: assert property (@(posedge clk)
		$rose(nrst) |-> !stall)
		else $error("stall high in the first cycle after reset");

	// Memory back-pressure freezes stage 4
	holdKeepsRd4: assert property (@(posedge clk) disable iff (!nrst)
		hold |=> $stable(rd4))
		else $error("rd4 changed while hold was high");

endmodule

bind issueStage issueStageProperties props (
	.clk(clk),
	.nrst(nrst),
	.bjTaken(bjTaken),
	.we4(we4),
	.stall(stall),
	.hold(hold),
	.rd4(rd4)
);

`default_nettype wire

// File: sim/issueStageTb.sv
`timescale 1ns/100ps
`default_nettype none

module issueStageTb;
	import rvIsaPkg::*;
	import issueCtrlPkg::*;

	localparam int clkPeriod = 100;
	localparam int resetCycles = 16;
	// Reset plus the cycles of each test, stalls included
	localparam int plannedCycles = resetCycles + 32 + 6 + 4 + 9 + 14 + 10 + 4;

	logic clk;
	logic nrst;
	logic [regAddrW-1:0] rs1, rs2, rd3;
	logic we3;
	logic [aluFnW-1:0] aluFn3;
	logic [bSelW-1:0] bSel3;
	logic [xlen-1:0] iImm3;
	logic [shamtW-1:0] shamt3;
	logic [memOpW-1:0] memOp3;
	logic [mulDivOpW-1:0] mulDivOp3;
	logic [xlen-1:0] pc3;
	logic [csrAddrW-1:0] csrAddr3;
	logic csrWe3, ecall3, illegal3, mret3;
	logic [xlen-1:0] opA, opB;
	logic [regAddrW-1:0] rd4;
	logic we4;
	logic [aluFnW-1:0] aluFn4;
	logic [memOpW-1:0] memOp4;
	logic [mulDivOpW-1:0] mulDivOp4;
	logic [xlen-1:0] pc4;
	logic [csrAddrW-1:0] csrAddr4;
	logic csrWe4;
	logic [xlen-1:0] csrData;
	logic ecall4, illegal4, mret4;
	logic we6;
	logic [regAddrW-1:0] rdAddr6;
	logic [xlen-1:0] wb6;
	logic csrWe6;
	logic [csrAddrW-1:0] csrWbAddr;
	logic [xlen-1:0] csrWb;
	logic excPending;
	logic [xlen-1:0] cause, pcExc;
	logic mRet;
	logic [xlen-1:0] epc, trapVector;
	logic bjTaken, exception, stallMem, stall;

	// Reference model state
	logic [xlen-1:0] regModel [0:31];
	logic [31:0] busyModel;
	int squashLeft;
	mstatusWord mstatusModel;
	logic [xlen-1:0] mtvecModel, mepcModel, mcauseModel, mscratchModel;

	// Expected stage-4 contents
	logic expValid;
	logic [regAddrW-1:0] expRd4;
	logic expWe4, expCsrWe4, expEcall4, expIllegal4, expMret4;
	logic [memOpW-1:0] expMemOp4;
	logic [mulDivOpW-1:0] expMulDivOp4;
	logic [xlen-1:0] expOpA, expOpB, expPc4;
	logic [aluFnW-1:0] expAluFn4;
	logic [csrAddrW-1:0] expCsrAddr4;

	int checks, errors, errorsAtStart;
	logic [xlen-1:0] pcNext;

	issueStage UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [xlen-1:0] refRead(input logic [regAddrW-1:0] addr);
		if (addr == '0)
			return '0;
		// Commit data written this cycle is seen right away
		if (we6 && (rdAddr6 == addr))
			return wb6;
		return regModel[addr];
	endfunction

	function automatic logic [xlen-1:0] refCsr(input logic [csrAddrW-1:0] addr);
		case (addr)
			csrMstatus: return mstatusModel.raw;
			csrMtvec: return mtvecModel;
			csrMepc: return mepcModel;
			csrMcause: return mcauseModel;
			csrMscratch: return mscratchModel;
			default: return '0;
		endcase
	endfunction

	function automatic logic [xlen-1:0] refOpB(input logic [bSelW-1:0] sel,
		input logic [xlen-1:0] regVal, input logic [xlen-1:0] imm,
		input logic [shamtW-1:0] sh);
		case (sel)
			bSelImm: return imm;
			bSelShamt: return {{(xlen - shamtW){1'b0}}, sh};
			default: return regVal;
		endcase
	endfunction

	// Bit 2 stall, bit 1 bubble, bit 0 hold
	function automatic logic [2:0] refControl();
		logic srcBusy;
		logic loadUse;
		logic squash;
		logic bub;
		srcBusy = (busyModel[rs1] && !(we6 && (rdAddr6 == rs1)))
			|| (busyModel[rs2] && !(we6 && (rdAddr6 == rs2)));
		loadUse = expMemOp4[memLoadBit] && (expRd4 != '0)
			&& ((expRd4 == rs1) || (expRd4 == rs2));
		squash = bjTaken || (squashLeft != 0);
		bub = exception || squash || srcBusy || loadUse;
		return {!exception && !squash && (srcBusy || loadUse || stallMem), bub, !bub && stallMem};
	endfunction

	task automatic resetModel();
		for (int i = 0; i < 32; i++)
			regModel[i] = '0;
		busyModel = '0;
		squashLeft = 0;
		mstatusModel.raw = '0;
		mtvecModel = '0;
		mepcModel = '0;
		mcauseModel = '0;
		mscratchModel = '0;
		expValid = 1'b0;
		expRd4 = '0;
		expWe4 = 1'b0;
		expCsrWe4 = 1'b0;
		expEcall4 = 1'b0;
		expIllegal4 = 1'b0;
		expMret4 = 1'b0;
		expMemOp4 = memNone;
		expMulDivOp4 = mulDivNone;
	endtask

	// Advance the model by the edge that follows
	task automatic stepModel();
		logic [2:0] ctl;
		ctl = refControl();
		if (ctl[1])
		begin
			expValid = 1'b0;
			expRd4 = '0;
			expWe4 = 1'b0;
			expCsrWe4 = 1'b0;
			expEcall4 = 1'b0;
			expIllegal4 = 1'b0;
			expMret4 = 1'b0;
			expMemOp4 = memNone;
			expMulDivOp4 = mulDivNone;
		end
		else if (!ctl[0])
		begin
			expValid = 1'b1;
			expOpA = refRead(rs1);
			expOpB = refOpB(bSel3, refRead(rs2), iImm3, shamt3);
			expRd4 = rd3;
			expWe4 = we3;
			expAluFn4 = aluFn3;
			expMemOp4 = memOp3;
			expMulDivOp4 = mulDivOp3;
			expPc4 = pc3;
			expCsrAddr4 = csrAddr3;
			expCsrWe4 = csrWe3;
			expEcall4 = ecall3;
			expIllegal4 = illegal3;
			expMret4 = mret3;
		end
		if (we6)
			busyModel[rdAddr6] = 1'b0;
		if (!ctl[1] && !ctl[0] && (mulDivOp3 != mulDivNone) && (rd3 != '0))
			busyModel[rd3] = 1'b1;
		// The bjTaken cycle is the first of the bubbles
		if (bjTaken)
			squashLeft = squashDepth - 1;
		else if (squashLeft > 0)
			squashLeft--;
		if (we6 && (rdAddr6 != '0))
			regModel[rdAddr6] = wb6;
		if (excPending)
		begin
			mepcModel = pcExc;
			mcauseModel = cause;
			mstatusModel.f.mpie = mstatusModel.f.mie;
			mstatusModel.f.mie = 1'b0;
		end
		else if (mRet)
		begin
			mstatusModel.f.mie = mstatusModel.f.mpie;
			mstatusModel.f.mpie = 1'b1;
		end
		else if (csrWe6)
		begin
			case (csrWbAddr)
				csrMstatus: mstatusModel.raw = csrWb;
				csrMtvec: mtvecModel = csrWb;
				csrMepc: mepcModel = csrWb;
				csrMcause: mcauseModel = csrWb;
				csrMscratch: mscratchModel = csrWb;
				default: ;
			endcase
		end
	endtask

	//////////////////////////////////////////////////////////////
	// Checker

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			$display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic compareOutputs();
		logic [2:0] ctl;
		ctl = refControl();
		checkValue("stall", stall, ctl[2]);
		checkValue("we4", we4, expWe4);
		checkValue("rd4", rd4, expRd4);
		checkValue("memOp4", memOp4, expMemOp4);
		checkValue("mulDivOp4", mulDivOp4, expMulDivOp4);
		checkValue("csrWe4", csrWe4, expCsrWe4);
		checkValue("ecall4", ecall4, expEcall4);
		checkValue("illegal4", illegal4, expIllegal4);
		checkValue("mret4", mret4, expMret4);
		checkValue("epc", epc, mepcModel);
		checkValue("trapVector", trapVector, mtvecModel);
		// Payload of a bubble is don't-care
		if (expValid)
		begin
			checkValue("opA", opA, expOpA);
			checkValue("opB", opB, expOpB);
			checkValue("aluFn4", aluFn4, expAluFn4);
			checkValue("pc4", pc4, expPc4);
			checkValue("csrAddr4", csrAddr4, expCsrAddr4);
			checkValue("csrData", csrData, refCsr(expCsrAddr4));
		end
	endtask

	// Inputs are stable between the falling edge and the next rising edge
	always @(negedge clk)
	begin
		if (nrst)
		begin
			compareOutputs();
			stepModel();
		end
	end

	initial
	begin
		#(plannedCycles * 2 * clkPeriod);
		$display("Watchdog expired before the tests completed");
		$display("Testbench failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////
	// Stimulus helpers

	// Pulse inputs last one cycle unless set again
	task automatic nextEdge();
		@(posedge clk);
		we6 <= 1'b0;
		csrWe6 <= 1'b0;
		excPending <= 1'b0;
		mRet <= 1'b0;
		bjTaken <= 1'b0;
		exception <= 1'b0;
	endtask

	task automatic setDecode(input logic [regAddrW-1:0] a, input logic [regAddrW-1:0] b,
		input logic [regAddrW-1:0] rd, input logic we, input logic [aluFnW-1:0] fn,
		input logic [bSelW-1:0] sel, input logic [xlen-1:0] imm,
		input logic [shamtW-1:0] sh, input logic [memOpW-1:0] mem,
		input logic [mulDivOpW-1:0] md);
		rs1 <= a;
		rs2 <= b;
		rd3 <= rd;
		we3 <= we;
		aluFn3 <= fn;
		bSel3 <= sel;
		iImm3 <= imm;
		shamt3 <= sh;
		memOp3 <= mem;
		mulDivOp3 <= md;
		pc3 <= pcNext;
		pcNext = pcNext + 4;
		csrAddr3 <= '0;
		csrWe3 <= 1'b0;
		ecall3 <= 1'b0;
		illegal3 <= 1'b0;
		mret3 <= 1'b0;
	endtask

	task automatic presentInstr(input logic [regAddrW-1:0] a, input logic [regAddrW-1:0] b,
		input logic [regAddrW-1:0] rd, input logic [bSelW-1:0] sel,
		input logic [memOpW-1:0] mem, input logic [mulDivOpW-1:0] md);
		nextEdge();
		setDecode(a, b, rd, rd != '0, $urandom, sel, $urandom, $urandom, mem, md);
	endtask

	// Hold the presented fields until the stage takes them
	task automatic waitIssue(output int stalls);
		stalls = 0;
		@(negedge clk);
		while (stall && (stalls < 50))
		begin
			nextEdge();
			@(negedge clk);
			stalls++;
		end
		if (stall)
		begin
			$display("Instruction never issued, stall stayed high at %0t", $time);
			errors++;
		end
	endtask

	task automatic startTest();
		errorsAtStart = errors;
	endtask

	task automatic finishTest(input string name);
		$display("Test %s finished with %0d errors", name, errors - errorsAtStart);
	endtask

	//////////////////////////////////////////////////////////////
	// Tests

	initial
	begin
		int stalls;
		logic [regAddrW-1:0] a, b, w;
		logic [bSelW-1:0] sel;
		void'($urandom(32'h6b10));
		checks = 0;
		errors = 0;
		pcNext = 32'h0000_1000;
		nrst = 1'b0;
		rs1 = '0;
		rs2 = '0;
		rd3 = '0;
		we3 = 1'b0;
		aluFn3 = '0;
		bSel3 = bSelReg;
		iImm3 = '0;
		shamt3 = '0;
		memOp3 = memNone;
		mulDivOp3 = mulDivNone;
		pc3 = '0;
		csrAddr3 = '0;
		csrWe3 = 1'b0;
		ecall3 = 1'b0;
		illegal3 = 1'b0;
		mret3 = 1'b0;
		we6 = 1'b0;
		rdAddr6 = '0;
		wb6 = '0;
		csrWe6 = 1'b0;
		csrWbAddr = '0;
		csrWb = '0;
		excPending = 1'b0;
		cause = '0;
		pcExc = '0;
		mRet = 1'b0;
		bjTaken = 1'b0;
		exception = 1'b0;
		stallMem = 1'b0;
		resetModel();
		repeat (resetCycles) @(posedge clk);
		nrst <= 1'b1;

		// Random writebacks against reads, with x0 and same-cycle forwarding
		startTest();
		for (int i = 0; i < 32; i++)
		begin
			a = $urandom;
			b = $urandom;
			w = $urandom;
			if (i == 0)
				a = '0;
			if ((i % 4) == 1)
				w = b;
			presentInstr(a, b, 5'd0, bSelReg, memNone, mulDivNone);
			we6 <= 1'b1;
			rdAddr6 <= w;
			wb6 <= $urandom;
			waitIssue(stalls);
		end
		finishTest("register file");

		startTest();
		for (int i = 0; i < 6; i++)
		begin
			sel = ((i % 3) == 0) ? bSelReg : (((i % 3) == 1) ? bSelImm : bSelShamt);
			presentInstr($urandom, $urandom, 5'd1 + 5'($urandom % 31), sel, memSw, mulDivNone);
			csrAddr3 <= csrMtvec;
			csrWe3 <= $urandom;
			ecall3 <= $urandom;
			illegal3 <= $urandom;
			mret3 <= $urandom;
			// Fresh trap vector each step
			csrWe6 <= 1'b1;
			csrWbAddr <= csrMtvec;
			csrWb <= $urandom;
			waitIssue(stalls);
		end
		finishTest("operand B select");

		startTest();
		presentInstr(5'd1, 5'd2, 5'd7, bSelImm, memLw, mulDivNone);
		waitIssue(stalls);
		presentInstr(5'd7, 5'd3, 5'd8, bSelReg, memNone, mulDivNone);
		we6 <= 1'b1;
		rdAddr6 <= 5'd7;
		wb6 <= $urandom;
		waitIssue(stalls);
		if (stalls != 1)
		begin
			$display("Load-use stalled %0d cycles instead of one", stalls);
			errors++;
		end
		finishTest("load-use hazard");

		startTest();
		presentInstr(5'd1, 5'd2, 5'd9, bSelReg, memNone, 4'h1);
		waitIssue(stalls);
		presentInstr(5'd3, 5'd4, 5'd10, bSelReg, memNone, mulDivNone);
		waitIssue(stalls);
		if (stalls != 0)
		begin
			$display("Independent instruction stalled behind a multiply");
			errors++;
		end
		presentInstr(5'd9, 5'd0, 5'd11, bSelReg, memNone, mulDivNone);
		repeat (3)
		begin
			@(negedge clk);
			if (!stall)
			begin
				$display("Dependent instruction issued before the multiply result");
				errors++;
			end
			nextEdge();
		end
		we6 <= 1'b1;
		rdAddr6 <= 5'd9;
		wb6 <= $urandom;
		waitIssue(stalls);
		finishTest("multiply dependency");

		startTest();
		presentInstr(5'd1, 5'd2, 5'd12, bSelReg, memNone, mulDivNone);
		waitIssue(stalls);
		// Next two are wrong-path
		presentInstr(5'd3, 5'd4, 5'd13, bSelReg, memNone, mulDivNone);
		bjTaken <= 1'b1;
		waitIssue(stalls);
		presentInstr(5'd5, 5'd6, 5'd14, bSelReg, memNone, mulDivNone);
		waitIssue(stalls);
		presentInstr(5'd7, 5'd8, 5'd15, bSelReg, memNone, mulDivNone);
		waitIssue(stalls);
		presentInstr(5'd9, 5'd10, 5'd16, bSelReg, memNone, mulDivNone);
		exception <= 1'b1;
		waitIssue(stalls);
		presentInstr(5'd11, 5'd12, 5'd17, bSelImm, memNone, mulDivNone);
		waitIssue(stalls);
		presentInstr(5'd13, 5'd14, 5'd18, bSelReg, memNone, mulDivNone);
		stallMem <= 1'b1;
		repeat (4)
		begin
			@(negedge clk);
			nextEdge();
		end
		stallMem <= 1'b0;
		waitIssue(stalls);
		finishTest("branch, discard and memory hold");

		startTest();
		presentInstr(5'd0, 5'd0, 5'd0, bSelReg, memNone, mulDivNone);
		csrWe6 <= 1'b1;
		csrWbAddr <= csrMscratch;
		csrWb <= $urandom;
		waitIssue(stalls);
		presentInstr(5'd0, 5'd0, 5'd0, bSelReg, memNone, mulDivNone);
		csrAddr3 <= csrMscratch;
		csrWe6 <= 1'b1;
		csrWbAddr <= csrMstatus;
		csrWb <= 32'h0000_0008;
		waitIssue(stalls);
		presentInstr(5'd0, 5'd0, 5'd0, bSelReg, memNone, mulDivNone);
		csrAddr3 <= csrMstatus;
		excPending <= 1'b1;
		cause <= causeEcall;
		pcExc <= $urandom & 32'hffff_fffc;
		waitIssue(stalls);
		presentInstr(5'd0, 5'd0, 5'd0, bSelReg, memNone, mulDivNone);
		csrAddr3 <= csrMstatus;
		waitIssue(stalls);
		presentInstr(5'd0, 5'd0, 5'd0, bSelReg, memNone, mulDivNone);
		csrAddr3 <= csrMcause;
		mRet <= 1'b1;
		waitIssue(stalls);
		presentInstr(5'd0, 5'd0, 5'd0, bSelReg, memNone, mulDivNone);
		csrAddr3 <= csrMstatus;
		waitIssue(stalls);
		presentInstr(5'd0, 5'd0, 5'd0, bSelReg, memNone, mulDivNone);
		csrAddr3 <= csrMepc;
		waitIssue(stalls);
		finishTest("CSR file");

		repeat (2) nextEdge();
		@(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
verilog/rvIsaPkg.sv
verilog/issueCtrlPkg.sv
verilog/regFile.sv
verilog/hazardScoreboard.sv
verilog/csrFile.sv
verilog/issueStage.sv
sim/issueStage_properties.sv
sim/issueStageTb.sv

// File: Bender.yml
package:
  name: issue_stage

sources:
  # Packages first, then the blocks, then the top level
  - files:
      - verilog/rvIsaPkg.sv
      - verilog/issueCtrlPkg.sv
      - verilog/regFile.sv
      - verilog/hazardScoreboard.sv
      - verilog/csrFile.sv
      - verilog/issueStage.sv
  - target: simulation
    files:
      - sim/issueStage_properties.sv
      - sim/issueStageTb.sv
